/* rtl/cop0Pkg.sv */
`default_nettype none

package cop0Pkg;

  // bus and register widths.
  localparam int dataWidth   = 32;
  localparam int addrWidth   = 5;
  localparam int irqCount    = 6;
  localparam int extIrqCount = 4;

  // register map.
  localparam logic [addrWidth-1:0] addrCount   = 5'd9;
  localparam logic [addrWidth-1:0] addrCompare = 5'd11;
  localparam logic [addrWidth-1:0] addrStatus  = 5'd12;
  localparam logic [addrWidth-1:0] addrCause   = 5'd13;
  localparam logic [addrWidth-1:0] addrEpc     = 5'd14;

  // pending field in Cause and mask field in Status share this base.
  localparam int ipLow = 10;
  localparam int ieBit = 0;

  // interrupt source order.
  localparam int irqUart0    = 0;
  localparam int irqUart1    = 1;
  localparam int irqFrame    = 2;
  localparam int irqGp       = 3;
  localparam int irqOverflow = 4;
  localparam int irqTimer    = 5;

  localparam logic [dataWidth-1:0] compareReset = 32'h0000_FFFF;

  // 1 = rising-edge capture, 0 = level. only the frame line is edge.
  localparam logic [extIrqCount-1:0] extEdgeMask = 4'b0100;

endpackage

`default_nettype wire

/* rtl/cop0BusPort.sv */
`timescale 1ns/1ps
`default_nettype none

module cop0BusPort (
  input  wire logic                          Clock,
  input  wire logic                          rstN,
  input  wire logic                          hostReq,
  input  wire logic                          hostWrite,
  input  wire logic [cop0Pkg::addrWidth-1:0] hostAddr,
  input  wire logic [cop0Pkg::dataWidth-1:0] hostWdata,
  input  wire logic [cop0Pkg::dataWidth-1:0] regRdata,
  output logic                               hostAck,
  output logic      [cop0Pkg::dataWidth-1:0] hostRdata,
  output logic                               regWrite,
  output logic                               regRead,
  output logic      [cop0Pkg::addrWidth-1:0] regAddr,
  output logic      [cop0Pkg::dataWidth-1:0] regWdata
);
  import cop0Pkg::*;

  typedef enum logic [1:0] {portIdle, portAccess, portAck} portStateT;

  portStateT state;
  logic reqQ;
  logic writeQ;
  logic [addrWidth-1:0] addrQ;
  logic [dataWidth-1:0] wdataQ;
  logic [dataWidth-1:0] rdataQ;
  logic strobe;

  // one access per transfer, fired on the first idle cycle with req seen.
  assign strobe    = (state == portIdle) && reqQ;
  assign regWrite  = strobe && writeQ;
  assign regRead   = strobe && !writeQ;
  assign regAddr   = addrQ;
  assign regWdata  = wdataQ;
  assign hostRdata = rdataQ;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      reqQ    <= 1'b0;
      state   <= portIdle;
      hostAck <= 1'b0;
    end else begin
      reqQ <= hostReq;
      case (state)
        portIdle: if (reqQ) state <= portAccess;
        portAccess: begin
          state   <= portAck;
          hostAck <= 1'b1;
        end
        portAck: begin
          if (!reqQ) begin // host released, drop ack.
            state   <= portIdle;
            hostAck <= 1'b0;
          end
        end
        default: state <= portIdle;
      endcase
    end
  end

  // request fields are stable while req is up.
  always_ff @(posedge Clock) begin
    if (state == portIdle) begin
      writeQ <= hostWrite;
      addrQ  <= hostAddr;
      wdataQ <= hostWdata;
    end
    if (regRead) rdataQ <= regRdata; // held until next read.
  end

endmodule

`default_nettype wire

/* rtl/irqSync.sv */
`timescale 1ns/1ps
`default_nettype none

module irqSync (
  input  wire logic                            Clock,
  input  wire logic                            rstN,
  input  wire logic [cop0Pkg::extIrqCount-1:0] extIrq,
  output logic      [cop0Pkg::extIrqCount-1:0] extIrqSync
);
  import cop0Pkg::*;

  logic [extIrqCount-1:0] sync1;
  logic [extIrqCount-1:0] sync2;
  logic [extIrqCount-1:0] sync3;
  logic [extIrqCount-1:0] pulseQ;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      sync1  <= '0;
      sync2  <= '0;
      sync3  <= '0;
      pulseQ <= '0;
    end else begin
      sync1  <= extIrq;
      sync2  <= sync1;
      sync3  <= sync2;
      pulseQ <= sync2 & ~sync3; // rising edge, one cycle wide.
    end
  end

  // edge lines take the pulse, the rest pass the level.
  assign extIrqSync = (pulseQ & extEdgeMask) | (sync2 & ~extEdgeMask);

endmodule

`default_nettype wire

/* rtl/cop0Regs.sv */
`timescale 1ns/1ps
`default_nettype none

module cop0Regs (
  input  wire logic                            Clock,
  input  wire logic                            rstN,
  input  wire logic                            regWrite,
  input  wire logic                            regRead,
  input  wire logic [cop0Pkg::addrWidth-1:0]   regAddr,
  input  wire logic [cop0Pkg::dataWidth-1:0]   regWdata,
  input  wire logic [cop0Pkg::extIrqCount-1:0] extIrqSync,
  input  wire logic                            intHandled,
  input  wire logic [cop0Pkg::dataWidth-1:0]   handledPc,
  output logic      [cop0Pkg::dataWidth-1:0]   regRdata,
  output logic                                 irqPending
);
  import cop0Pkg::*;

  logic [dataWidth-1:0] epc;
  logic [dataWidth-1:0] count;
  logic [dataWidth-1:0] compare;
  logic [dataWidth-1:0] status;
  logic [dataWidth-1:0] cause;
  logic [irqCount-1:0]  shadowIp; // sources seen while disabled.

  logic [irqCount-1:0] sources;
  logic [irqCount-1:0] ip;
  logic [irqCount-1:0] im;
  logic [irqCount-1:0] nextIp;
  logic [irqCount-1:0] causeIp;
  logic ie;
  logic timerFire;
  logic overflowFire;
  logic wrCount;
  logic wrCompare;
  logic wrStatus;
  logic wrCause;
  logic [dataWidth-1:0] readMux;

  assign wrCount   = regWrite && (regAddr == addrCount);
  assign wrCompare = regWrite && (regAddr == addrCompare);
  assign wrStatus  = regWrite && (regAddr == addrStatus);
  assign wrCause   = regWrite && (regAddr == addrCause);

  assign timerFire    = (count == compare);
  assign overflowFire = &count;

  always_comb begin
    sources                    = '0;
    sources[extIrqCount-1:0]   = extIrqSync; // external lines sit at the bottom.
    sources[irqOverflow]       = overflowFire;
    sources[irqTimer]          = timerFire;
  end

  assign ip = cause[ipLow +: irqCount];
  assign im = status[ipLow +: irqCount];
  assign ie = status[ieBit];

  // with enable low the pending bits freeze.
  assign nextIp = ie ? (ip | sources | shadowIp) : ip;

  // compare write acknowledges the timer.
  always_comb begin
    causeIp = nextIp;
    if (wrCompare) causeIp[irqTimer] = 1'b0;
  end

  assign irqPending = ie && |(im & ip) && !regWrite;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      epc      <= '0;
      count    <= '0;
      compare  <= compareReset;
      status   <= '0;
      cause    <= '0;
      shadowIp <= '0;
    end else begin
      count <= wrCount ? regWdata : count + 1'b1;

      if (wrCompare) compare <= regWdata;

      if (intHandled) epc <= handledPc;

      if (wrStatus) begin
        status <= regWdata;
      end else if (intHandled) begin
        status[ieBit] <= 1'b0; // enter handler with interrupts off.
      end

      if (wrCause) begin
        cause <= regWdata;
      end else begin
        cause[ipLow +: irqCount] <= causeIp;
      end

      if (intHandled || ie) begin
        shadowIp <= '0;
      end else begin
        shadowIp <= shadowIp | sources;
      end
    end
  end

  always_comb begin
    case (regAddr)
      addrEpc:     readMux = epc;
      addrCount:   readMux = count;
      addrCompare: readMux = compare;
      addrStatus:  readMux = status;
      addrCause:   readMux = cause;
      default:     readMux = '0; // unmapped.
    endcase
  end

  assign regRdata = regRead ? readMux : '0;

endmodule

`default_nettype wire

/* rtl/exceptionSeq.sv */
`timescale 1ns/1ps
`default_nettype none

module exceptionSeq (
  input  wire logic                          Clock,
  input  wire logic                          rstN,
  input  wire logic                          irqPending,
  input  wire logic                          irqAck,
  input  wire logic [cop0Pkg::dataWidth-1:0] epcIn,
  output logic                               irqReq,
  output logic                               intHandled,
  output logic      [cop0Pkg::dataWidth-1:0] handledPc
);
  import cop0Pkg::*;

  typedef enum logic [1:0] {seqIdle, seqRequest, seqWaitRelease} seqStateT;

  seqStateT state;

  always_ff @(posedge Clock) begin
    if (!rstN) begin
      state      <= seqIdle;
      irqReq     <= 1'b0;
      intHandled <= 1'b0;
    end else begin
      intHandled <= 1'b0;
      case (state)
        seqIdle: begin
          if (irqPending) begin
            irqReq <= 1'b1;
            state  <= seqRequest;
          end
        end
        seqRequest: begin
          // core took the interrupt.
          if (irqAck) begin
            irqReq     <= 1'b0;
            intHandled <= 1'b1;
            state      <= seqWaitRelease;
          end
        end
        seqWaitRelease: if (!irqAck) state <= seqIdle;
        default: begin
          irqReq <= 1'b0;
          state  <= seqIdle;
        end
      endcase
    end
  end

  // pc of the interrupted instruction, valid with ack.
  always_ff @(posedge Clock) begin
    if (state == seqRequest && irqAck) handledPc <= epcIn;
  end

endmodule

`default_nettype wire

/* rtl/cop0Top.sv */
`timescale 1ns/1ps
`default_nettype none

module cop0Top (
  input  wire logic                            Clock,
  input  wire logic                            rstN,
  input  wire logic                            hostReq,
  input  wire logic                            hostWrite,
  input  wire logic [cop0Pkg::addrWidth-1:0]   hostAddr,
  input  wire logic [cop0Pkg::dataWidth-1:0]   hostWdata,
  input  wire logic [cop0Pkg::extIrqCount-1:0] extIrq,
  input  wire logic                            irqAck,
  input  wire logic [cop0Pkg::dataWidth-1:0]   epcIn,
  output logic                                 hostAck,
  output logic      [cop0Pkg::dataWidth-1:0]   hostRdata,
  output logic                                 irqReq
);
  import cop0Pkg::*;

  logic regWrite;
  logic regRead;
  logic [addrWidth-1:0] regAddr;
  logic [dataWidth-1:0] regWdata;
  logic [dataWidth-1:0] regRdata;
  logic [extIrqCount-1:0] extIrqSync;
  logic irqPending;
  logic intHandled;
  logic [dataWidth-1:0] handledPc;

  cop0BusPort i_busPort (
    .Clock     (Clock),
    .rstN      (rstN),
    .hostReq   (hostReq),
    .hostWrite (hostWrite),
    .hostAddr  (hostAddr),
    .hostWdata (hostWdata),
    .regRdata  (regRdata),
    .hostAck   (hostAck),
    .hostRdata (hostRdata),
    .regWrite  (regWrite),
    .regRead   (regRead),
    .regAddr   (regAddr),
    .regWdata  (regWdata)
  );

  irqSync i_irqSync (
    .Clock      (Clock),
    .rstN       (rstN),
    .extIrq     (extIrq),
    .extIrqSync (extIrqSync)
  );

  cop0Regs i_regs (
    .Clock      (Clock),
    .rstN       (rstN),
    .regWrite   (regWrite),
    .regRead    (regRead),
    .regAddr    (regAddr),
    .regWdata   (regWdata),
    .extIrqSync (extIrqSync),
    .intHandled (intHandled),
    .handledPc  (handledPc),
    .regRdata   (regRdata),
    .irqPending (irqPending)
  );

  exceptionSeq i_exceptionSeq (
    .Clock      (Clock),
    .rstN       (rstN),
    .irqPending (irqPending),
    .irqAck     (irqAck),
    .epcIn      (epcIn),
    .irqReq     (irqReq),
    .intHandled (intHandled),
    .handledPc  (handledPc)
  );

endmodule

`default_nettype wire

/* testbench/cop0Tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cop0Tb #(
  parameter int unsigned rngSeed = 32'h568a_2fdc
);
  import cop0Pkg::*;

  localparam int    halfPeriod      = 2; // 4 ns clock.
  localparam int    resetCycles     = 2;
  localparam int    cyclesPerVector = 64;
  localparam int    ackEdges        = 4; // one edge to sample req, two to raise ack, one to see it.
  localparam string vectorFile      = "testbench/cop0Vectors.txt";

  // vector operation codes.
  localparam logic [31:0] opWrite = 32'd0;
  localparam logic [31:0] opRead  = 32'd1;
  localparam logic [31:0] opCount = 32'd2;
  localparam logic [31:0] opPins  = 32'd3;
  localparam logic [31:0] opWait  = 32'd4;
  localparam logic [31:0] opIrq   = 32'd5;
  localparam logic [31:0] opAck   = 32'd6;
  localparam logic [31:0] opEnd   = 32'd7;

  logic                   Clock;
  logic                   rstN;
  logic                   hostReq;
  logic                   hostWrite;
  logic [addrWidth-1:0]   hostAddr;
  logic [dataWidth-1:0]   hostWdata;
  logic [extIrqCount-1:0] extIrq;
  logic                   irqAck;
  logic [dataWidth-1:0]   epcIn;
  logic                   hostAck;
  logic [dataWidth-1:0]   hostRdata;
  logic                   irqReq;

  logic [31:0] vecOp[$];
  logic [31:0] vecArg[$];
  logic [31:0] vecData[$];
  logic [31:0] vecExp[$];

  int checkCount;
  int errorCount;
  int testCount;
  int checkBase;
  int errorBase;
  bit vectorsLoaded;

  cop0Top i_dut (
    .Clock     (Clock),
    .rstN      (rstN),
    .hostReq   (hostReq),
    .hostWrite (hostWrite),
    .hostAddr  (hostAddr),
    .hostWdata (hostWdata),
    .extIrq    (extIrq),
    .irqAck    (irqAck),
    .epcIn     (epcIn),
    .hostAck   (hostAck),
    .hostRdata (hostRdata),
    .irqReq    (irqReq)
  );

  initial begin
    Clock = 1'b0;
    forever #halfPeriod Clock = ~Clock;
  end

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t ns: %s, got 0x%08h, expected 0x%08h",
               $time, msg, actual, expected);
    end
  endtask

  task automatic loadVectors();
    int fd;
    int code;
    logic [31:0] f0;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [2047:0] skipLine;
    fd = $fopen(vectorFile, "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
      if (code == 4) begin
        vecOp.push_back(f0);
        vecArg.push_back(f1);
        vecData.push_back(f2);
        vecExp.push_back(f3);
      end else begin
        void'($fgets(skipLine, fd)); // comment or blank line.
      end
    end
    $fclose(fd);
  endtask

  // one four-phase transfer that returns with req dropped.
  task automatic hostTransfer(input logic wr, input logic [addrWidth-1:0] addr,
                              input logic [dataWidth-1:0] data,
                              output logic [dataWidth-1:0] rdata);
    int edges;
    while (hostAck) @(posedge Clock);
    hostReq   <= 1'b1;
    hostWrite <= wr;
    hostAddr  <= addr;
    hostWdata <= data;
    @(posedge Clock);
    edges = 1;
    while (!hostAck) begin
      @(posedge Clock);
      edges++;
    end
    checkValue(edges, ackEdges, "hostAck latency in clock edges");
    rdata = hostRdata;
    hostReq <= 1'b0;
  endtask

  task automatic waitForIrq(input logic [31:0] cycles, input logic wantHigh);
    logic seen;
    logic [31:0] n;
    seen = 1'b0;
    n = '0;
    while (n < cycles && !(seen && wantHigh)) begin
      @(posedge Clock);
      if (irqReq) seen = 1'b1;
      n++;
    end
    checkValue({31'b0, seen}, {31'b0, wantHigh},
               $sformatf("irqReq level within %0d cycles", cycles));
  endtask

  // core side of the interrupt handshake.
  task automatic coreAcknowledge(input logic [dataWidth-1:0] pc);
    int unsigned delay;
    checkValue({31'b0, irqReq}, 32'h1, "irqReq high before core acknowledge");
    if (irqReq) begin
      delay = 1 + ($urandom % 8);
      repeat (delay) @(posedge Clock);
      irqAck <= 1'b1;
      epcIn  <= pc;
      @(posedge Clock);
      while (irqReq) @(posedge Clock);
      irqAck <= 1'b0;
      @(posedge Clock);
    end
  endtask

  task automatic runStep(input int idx);
    logic [31:0] op;
    logic [31:0] arg;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] rdata;
    logic [31:0] offset;
    op       = vecOp[idx];
    arg      = vecArg[idx];
    data     = vecData[idx];
    expected = vecExp[idx];
    case (op)
      opWrite: hostTransfer(1'b1, arg[addrWidth-1:0], data, rdata);
      opRead: begin
        hostTransfer(1'b0, arg[addrWidth-1:0], 32'h0, rdata);
        checkValue(rdata & data, expected, $sformatf("read of address %0d", arg));
      end
      opCount: begin
        hostTransfer(1'b1, addrCount, data, rdata);
        repeat (arg) @(posedge Clock);
        hostTransfer(1'b0, addrCount, 32'h0, rdata);
        offset = rdata - data - arg; // wraps high when below the window.
        checkValue({31'b0, offset <= expected}, 32'h1,
                   $sformatf("count 0x%08h outside window after %0d idle cycles", rdata, arg));
      end
      opPins: begin
        extIrq <= data[extIrqCount-1:0];
        @(posedge Clock);
      end
      opWait: repeat (data) @(posedge Clock);
      opIrq: waitForIrq(data, expected[0]);
      opAck: coreAcknowledge(data);
      opEnd: begin
        testCount++;
        $display("test %0d done: %0d checks, %0d errors",
                 arg, checkCount - checkBase, errorCount - errorBase);
        checkBase = checkCount;
        errorBase = errorCount;
      end
      default: begin
        errorCount++;
        $display("vector %0d has an unknown operation %0d", idx, op);
      end
    endcase
  endtask

  initial begin
    rstN       = 1'b0;
    hostReq    = 1'b0;
    hostWrite  = 1'b0;
    hostAddr   = '0;
    hostWdata  = '0;
    extIrq     = '0;
    irqAck     = 1'b0;
    epcIn      = '0;
    checkCount = 0;
    errorCount = 0;
    testCount  = 0;
    checkBase  = 0;
    errorBase  = 0;
    void'($urandom(rngSeed));
    loadVectors();
    vectorsLoaded = 1'b1;
    if (vecOp.size() == 0) begin
      $display("no test vectors could be read from %s", vectorFile);
      errorCount++;
    end
    repeat (resetCycles) @(posedge Clock);
    rstN <= 1'b1;
    @(posedge Clock);
    foreach (vecOp[i]) runStep(i);
    $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog budget scales with the vector count.
  initial begin
    int limit;
    wait (vectorsLoaded);
    limit = cyclesPerVector * (vecOp.size() + 1);
    repeat (limit) @(posedge Clock);
    $display("the run timed out after %0d cycles before all vectors were done", limit);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/cop0Vectors.txt */
// columns: op addr data expected, all hex. op 0 write, 1 read (data = compare mask),
// 2 count window (addr = idle cycles, data = start, expected = width), 3 pins, 4 wait,
// 5 irqReq (data = cycles, expected = level), 6 core ack (data = epc), 7 end (addr = test).
1 0b ffffffff 0000ffff
1 0c ffffffff 00000000
1 0d ffffffff 00000000
1 0e ffffffff 00000000
1 03 ffffffff 00000000
7 01 0 0
2 05 00000100 6
2 14 00002000 6
7 02 0 0
0 09 00001000 0
0 0b 00001028 0
0 0c 00008001 0
5 00 3c 1
1 0d 00008000 00008000
0 0b ffff0000 0
1 0d 00008000 00000000
6 00 00000400 0
7 03 0 0
0 0c 00000801 0
3 00 2 0
5 00 14 1
6 00 bfc00180 0
1 0e ffffffff bfc00180
1 0c 00000001 00000000
5 00 1e 0
3 00 0 0
7 04 0 0
0 0d 0 0
3 00 4 0
4 00 2 0
3 00 0 0
5 00 14 0
1 0d 00001000 00000000
0 0c 00001001 0
5 00 14 1
1 0d 00001000 00001000
6 00 00002000 0
7 05 0 0
0 0d 0 0
0 0c 1 0
3 00 8 0
5 00 32 0
1 0d 00002000 00002000
3 00 0 0
7 06 0 0

/* project.f */
rtl/cop0Pkg.sv
rtl/cop0BusPort.sv
rtl/irqSync.sv
rtl/cop0Regs.sv
rtl/exceptionSeq.sv
rtl/cop0Top.sv
testbench/cop0Tb.sv

/* Makefile */
# Verilator simulation of the COP0 block.
VERILATOR ?= verilator
TOP       ?= cop0Tb
SEED      ?= 1451896796
LOG       ?= sim.log
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -GrngSeed=$(SEED) \
		--Mdir $(OBJDIR) -o V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "sim failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "Simulation completed successfully" $(LOG) || \
		{ echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
